// File: sim.f
hw/colmix_video_pkg.sv
hw/colmix_mem_pkg.sv
hw/prio_prom.sv
hw/pal_ram.sv
hw/blank_delay.sv
hw/colmix_core.sv
hw/colmix_top.sv
bench/colmix_assert.sv
bench/tb_colmix.sv

// File: Makefile
# Verilator build and run of the colour mixer testbench

VERILATOR ?= verilator
TOP       ?= tb_colmix
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= All tests passed

SRCS    := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass message shows up in the output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_colmix.sv
`timescale 1ns/1ps

module tb_colmix;

    // stimulus lengths in pixels
    localparam int n_start  = 512;
    localparam int n_vblank = 16;
    localparam int n_main   = 3000;
    localparam int n_window = 32;
    // extra pixels so the last word leaves the delay line
    localparam int n_drain  = colmix_video_pkg::PXL_DLY + 1;
    localparam int n_pixels = n_start + n_vblank + n_main + n_drain;
    // clocks spent in the two paused table loads
    localparam int load_cycles =
        2 * (colmix_mem_pkg::PRIO_DEPTH + 2) + colmix_mem_pkg::PAL_DEPTH;
    localparam int rst_cycles  = 4;
    localparam int max_cycles  =
        (4 * (n_pixels + colmix_video_pkg::PXL_DLY) + load_cycles + rst_cycles) * 11 / 10;

    // one expected video output
    // rgb_known is low when a write hit that pixel
    typedef struct packed {
        colmix_video_pkg::rgb_t rgb;
        logic                   lhbl;
        logic                   lvbl;
        logic                   rgb_known;
    } expect_t;

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         pxl_cen;
    logic                         pxl2_cen;
    colmix_video_pkg::char_pxl_t  char_pxl;
    colmix_video_pkg::scr_pxl_t   scr_pxl;
    colmix_video_pkg::obj_pxl_t   obj_pxl;
    logic                         lhbl;
    logic                         lvbl;
    colmix_mem_pkg::pal_wr_t      pal_wr;
    colmix_mem_pkg::prio_wr_t     prio_wr;
    logic [2:0]                   layer_en;
    colmix_video_pkg::rgb_t       rgb;
    logic                         lhbl_dly;
    logic                         lvbl_dly;

    // reference model state
    logic [1:0]  prom_mirror [colmix_mem_pkg::PRIO_DEPTH];
    logic [7:0]  pal_mirror [colmix_mem_pkg::PAL_DEPTH];
    logic        gray_model;
    expect_t     exp_q [$];
    // pending palette rewrites with the address in [17:8] and the data in [7:0]
    logic [17:0] pend_q [$];
    int          pix_cnt = 0;
    int          checked = 0;
    int          cycles = 0;

    colmix_top dut (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .pxl2_cen (pxl2_cen),
        .char_pxl (char_pxl),
        .scr_pxl  (scr_pxl),
        .obj_pxl  (obj_pxl),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .pal_wr   (pal_wr),
        .prio_wr  (prio_wr),
        .layer_en (layer_en),
        .rgb      (rgb),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly)
    );

    always #5 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("run timed out after %0d clocks", cycles);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    task automatic compare_rgb(input string name, input colmix_video_pkg::rgb_t got,
                               input colmix_video_pkg::rgb_t want);
        if (got !== want) begin
            $display("[FAIL] %s got %h expected %h at pixel %0d", name, got, want, pix_cnt);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic compare_blank(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("[FAIL] %s got %h expected %h at pixel %0d", name, got, want, pix_cnt);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // priority table index from scroll nibble, obj clear, char window,
    // scroll window and char solid
    function automatic logic [7:0] prio_index(input colmix_video_pkg::char_pxl_t c,
                                              input colmix_video_pkg::scr_pxl_t s,
                                              input colmix_video_pkg::obj_pxl_t o,
                                              input logic [2:0] en);
        logic obj_clear;
        logic char_solid;
        logic scr_window;
        obj_clear  = (o.col == 4'hf) || !en[2];
        char_solid = (c.idx != 2'b11) && en[0];
        scr_window = s.win && en[1];
        return {s.code[3:0], obj_clear, c.win, scr_window, char_solid};
    endfunction

    // 9-bit palette entry of the chosen layer
    function automatic logic [8:0] pal_index(input colmix_video_pkg::layer_sel_t sel,
                                             input colmix_video_pkg::char_pxl_t c,
                                             input colmix_video_pkg::scr_pxl_t s,
                                             input colmix_video_pkg::obj_pxl_t o);
        if (sel == colmix_video_pkg::CHAR_SEL) begin
            return {colmix_video_pkg::CHAR_PAL, 1'b1, c.grp, c.idx};
        end
        if (sel == colmix_video_pkg::OBJ_SEL) begin
            return {colmix_video_pkg::OBJ_PAL, o.grp, o.col};
        end
        return {colmix_video_pkg::SCR_PAL, s.code};
    endfunction

    // gray ramp until the first palette write and then red/green byte with blue nibble
    function automatic colmix_video_pkg::rgb_t expected_word(input logic [8:0] entry);
        logic [3:0]             ramp;
        colmix_video_pkg::rgb_t w;
        if (gray_model) begin
            ramp = ~entry[3:0];
            w = {ramp, ramp, ramp};
        end else begin
            w = {pal_mirror[{entry, 1'b0}], pal_mirror[{entry, 1'b1}][7:4]};
        end
        return w;
    endfunction

    // one pending palette write per clock and only in vertical blank
    task automatic drive_pal_write(output logic wrote);
        logic [17:0] w;
        wrote = 1'b0;
        pal_wr.we = 1'b0;
        if (!lvbl && pend_q.size() > 0) begin
            w = pend_q.pop_front();
            pal_wr.we = 1'b1;
            pal_wr.addr = w[17:8];
            pal_wr.data = w[7:0];
            pal_mirror[w[17:8]] = w[7:0];
            gray_model = 1'b0;
            wrote = 1'b1;
        end
    endtask

    task automatic queue_rewrites(input int n);
        logic [31:0] rnd;
        for (int i = 0; i < n; i++) begin
            rnd = $urandom();
            pend_q.push_back(rnd[17:0]);
        end
    endtask

    // called at c0 when the outputs hold the result of the last pxl_cen edge
    task automatic verify_outputs();
        expect_t ent;
        if (exp_q.size() > colmix_video_pkg::PXL_DLY) begin
            ent = exp_q.pop_front();
            if (ent.rgb_known) begin
                compare_rgb("rgb", rgb, ent.rgb);
            end
            compare_blank("lhbl_dly", lhbl_dly, ent.lhbl);
            compare_blank("lvbl_dly", lvbl_dly, ent.lvbl);
            checked++;
        end else begin
            // delay line still holds its reset contents
            compare_rgb("rgb", rgb, '0);
            compare_blank("lhbl_dly", lhbl_dly, 1'b0);
            compare_blank("lvbl_dly", lvbl_dly, 1'b0);
        end
    endtask

    // one pixel period c0..c3 with random layer pixels
    task automatic send_pixel(input logic active);
        expect_t                      ent;
        logic                         wrote;
        logic                         dirty;
        logic [31:0]                  rnd;
        colmix_video_pkg::layer_sel_t sel;
        @(negedge clk);
        verify_outputs();
        if (pix_cnt % 64 == 0) begin
            rnd = $urandom();
            layer_en = rnd[2:0];
        end
        rnd = $urandom();
        char_pxl = rnd[6:0];
        scr_pxl = rnd[14:7];
        obj_pxl = rnd[21:15];
        // make transparent objects more frequent
        if (rnd[23:22] == 2'b00) begin
            obj_pxl.col = 4'hf;
        end
        lhbl = (pix_cnt % 64) < 56;
        lvbl = active;
        pxl2_cen = 1'b0;
        pxl_cen = 1'b0;
        sel = prom_mirror[prio_index(char_pxl, scr_pxl, obj_pxl, layer_en)];
        ent.rgb = expected_word(pal_index(sel, char_pxl, scr_pxl, obj_pxl));
        ent.lhbl = lhbl;
        ent.lvbl = lvbl;
        drive_pal_write(dirty);
        for (int ph = 1; ph < 4; ph++) begin
            @(negedge clk);
            pxl2_cen = ph[0];
            pxl_cen = (ph == 3);
            drive_pal_write(wrote);
            dirty = dirty | wrote;
        end
        // a write inside the period may land between the two byte reads
        ent.rgb_known = !dirty;
        exp_q.push_back(ent);
        pix_cnt++;
    endtask

    // PROM reload and optionally the whole palette with the pixel clock stopped
    task automatic load_tables(input logic with_pal);
        logic [31:0] rnd;
        @(negedge clk);
        pxl_cen = 1'b0;
        pxl2_cen = 1'b0;
        lvbl = 1'b0;
        for (int a = 0; a < colmix_mem_pkg::PRIO_DEPTH; a++) begin
            rnd = $urandom();
            prio_wr.we = 1'b1;
            prio_wr.addr = a[7:0];
            prio_wr.data = rnd[1:0];
            prom_mirror[a[7:0]] = rnd[1:0];
            @(negedge clk);
        end
        prio_wr.we = 1'b0;
        if (with_pal) begin
            for (int a = 0; a < colmix_mem_pkg::PAL_DEPTH; a++) begin
                rnd = $urandom();
                pal_wr.we = 1'b1;
                pal_wr.addr = a[9:0];
                pal_wr.data = rnd[7:0];
                pal_mirror[a[9:0]] = rnd[7:0];
                gray_model = 1'b0;
                @(negedge clk);
            end
            pal_wr.we = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(32'h529f_e7d9));
        rst = 1'b1;
        pxl_cen = 1'b0;
        pxl2_cen = 1'b0;
        char_pxl = '0;
        scr_pxl = '0;
        obj_pxl = '0;
        lhbl = 1'b0;
        lvbl = 1'b0;
        pal_wr = '0;
        prio_wr = '0;
        layer_en = 3'b111;
        gray_model = 1'b1;
        repeat (rst_cycles) @(negedge clk);
        rst = 1'b0;
        // priority table before video starts with the palette left unwritten
        load_tables(1'b0);
        for (int i = 0; i < n_start; i++) begin
            send_pixel(1'b1);
        end
        // vertical blank with the full palette load and a new table
        for (int i = 0; i < n_vblank / 2; i++) begin
            send_pixel(1'b0);
        end
        load_tables(1'b1);
        for (int i = 0; i < n_vblank / 2; i++) begin
            send_pixel(1'b0);
        end
        // long run with two blanking windows of palette rewrites
        for (int i = 0; i < n_main; i++) begin
            if (i == 1000 || i == 2000) begin
                queue_rewrites(96);
            end
            send_pixel(!((i >= 1000 && i < 1000 + n_window) ||
                         (i >= 2000 && i < 2000 + n_window)));
        end
        for (int i = 0; i < n_drain; i++) begin
            send_pixel(1'b1);
        end
        // drain pixels push entries that never leave the queue
        if (checked == n_pixels - n_drain) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("only %0d of %0d pixels were compared", checked,
                     n_pixels - n_drain);
            $display("Some tests failed");
            $fatal(1);
        end
    end

endmodule

// File: bench/colmix_assert.sv
`timescale 1ns/1ps

module colmix_assert (
    input logic                   clk,
    input logic                   rst,
    input logic                   pxl_cen,
    input logic                   lsb,
    input logic                   gray,
    input colmix_video_pkg::rgb_t rgb
);

    // every pixel starts its fetch with the red/green byte
    lsb_after_cen: assert property (
        @(posedge clk) disable iff (rst) pxl_cen |=> !lsb
    ) else $error("byte select still high in the clock after pxl_cen");

    // start-up ramp is over for good once the CPU has written
    gray_stays_off: assert property (
        @(posedge clk) disable iff (rst) !$rose(gray)
    ) else $error("gray flag set again without a reset");

    // colour register always holds a known word
    rgb_known: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(rgb)
    ) else $error("colour word has unknown bits");

endmodule

// watch the fetch sequencing inside the mixer core
bind colmix_core colmix_assert u_assert (
    .clk     (clk),
    .rst     (rst),
    .pxl_cen (pxl_cen),
    .lsb     (lsb),
    .gray    (gray),
    .rgb     (rgb)
);

// File: hw/colmix_top.sv
`timescale 1ns/1ps

module colmix_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pxl_cen,
    input  logic                         pxl2_cen,
    // layer generators
    input  colmix_video_pkg::char_pxl_t  char_pxl,
    input  colmix_video_pkg::scr_pxl_t   scr_pxl,
    input  colmix_video_pkg::obj_pxl_t   obj_pxl,
    // blanking levels from the video timing
    input  logic                         lhbl,
    input  logic                         lvbl,
    // CPU palette writes and PROM loader
    input  colmix_mem_pkg::pal_wr_t      pal_wr,
    input  colmix_mem_pkg::prio_wr_t     prio_wr,
    input  logic [2:0]                   layer_en,
    output colmix_video_pkg::rgb_t       rgb,
    output logic                         lhbl_dly,
    output logic                         lvbl_dly
);

    logic [colmix_mem_pkg::PRIO_AW-1:0] prio_addr;
    colmix_video_pkg::layer_sel_t       prio;
    logic [colmix_mem_pkg::PAL_AW-1:0]  pal_rd_addr;
    logic [7:0]                         pal_q;
    colmix_video_pkg::rgb_t             core_rgb;

    colmix_core u_core (
        .clk         (clk),
        .rst         (rst),
        .pxl_cen     (pxl_cen),
        .pxl2_cen    (pxl2_cen),
        .char_pxl    (char_pxl),
        .scr_pxl     (scr_pxl),
        .obj_pxl     (obj_pxl),
        .layer_en    (layer_en),
        .pal_wr      (pal_wr),
        .prio_addr   (prio_addr),
        .prio        (prio),
        .pal_rd_addr (pal_rd_addr),
        .pal_q       (pal_q),
        .rgb         (core_rgb)
    );

    prio_prom u_prio (
        .clk  (clk),
        .wr   (prio_wr),
        .addr (prio_addr),
        .prio (prio)
    );

    pal_ram u_pal (
        .clk     (clk),
        .wr      (pal_wr),
        .rd_addr (pal_rd_addr),
        .q       (pal_q)
    );

    blank_delay u_blank (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .rgb_in   (core_rgb),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly),
        .rgb_out  (rgb)
    );

endmodule

// File: hw/colmix_core.sv
`timescale 1ns/1ps

module colmix_core (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            pxl_cen,
    input  logic                            pxl2_cen,
    // layer pixels, stable for the whole pixel period
    input  colmix_video_pkg::char_pxl_t     char_pxl,
    input  colmix_video_pkg::scr_pxl_t      scr_pxl,
    input  colmix_video_pkg::obj_pxl_t      obj_pxl,
    // bit 0 characters, bit 1 scroll, bit 2 objects
    input  logic [2:0]                      layer_en,
    // only the strobe is used here, for the gray flag
    input  colmix_mem_pkg::pal_wr_t         pal_wr,
    // priority table lookup
    output logic [7:0]                      prio_addr,
    input  colmix_video_pkg::layer_sel_t    prio,
    // palette read port
    output logic [9:0]                      pal_rd_addr,
    input  logic [7:0]                      pal_q,
    output colmix_video_pkg::rgb_t          rgb
);

    logic       obj_blank;
    logic       char_opaque;
    logic       char_win;
    logic       scr_win;
    logic [8:0] pal_addr;
    // palette byte select, 0 for red/green and 1 for blue
    logic       lsb;
    // red/green byte held until blue arrives
    logic [7:0] byte0;
    // set until the CPU writes the palette for the first time
    logic       gray;

    // disabled objects look fully transparent
    assign obj_blank = (&obj_pxl.col) | ~layer_en[2];

    // index 2'b11 is the transparent character colour
    assign char_opaque = ~(&char_pxl.idx) & layer_en[0];

    // window bits let a layer move ahead of another one in the table
    assign char_win = char_pxl.win;
    assign scr_win  = scr_pxl.win & layer_en[1];

    assign prio_addr = {scr_pxl.code[3:0], obj_blank, char_win, scr_win, char_opaque};

    // palette entry of the winning layer
    always_comb begin
        if (prio == colmix_video_pkg::CHAR_SEL) begin
            // characters use only the upper half of their bank
            pal_addr = {colmix_video_pkg::CHAR_PAL, 1'b1, char_pxl.grp, char_pxl.idx};
        end else if (prio == colmix_video_pkg::OBJ_SEL) begin
            pal_addr = {colmix_video_pkg::OBJ_PAL, obj_pxl.grp, obj_pxl.col};
        end else begin
            pal_addr = {colmix_video_pkg::SCR_PAL, scr_pxl.code};
        end
    end

    assign pal_rd_addr = {pal_addr, lsb};

    // byte select sequencing
    // c0 and c1 read byte 0, c2 and c3 read byte 1
    // pxl_cen wins since it always comes with pxl2_cen
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lsb <= 1'b0;
        end else if (pxl_cen) begin
            lsb <= 1'b0;
        end else if (pxl2_cen) begin
            lsb <= 1'b1;
        end
    end

    // byte 0 is on pal_q during c1, keep it for the end of the pixel
    always_ff @(posedge clk) begin
        if (pxl2_cen && !pxl_cen) begin
            byte0 <= pal_q;
        end
    end

    // start-up gray ramp, cleared for good by any palette write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gray <= 1'b1;
        end else if (pal_wr.we) begin
            gray <= 1'b0;
        end
    end

    // colour word, blue comes straight from the RAM in c3
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rgb <= '0;
        end else if (pxl_cen) begin
            if (gray) begin
                rgb <= '{r: ~pal_addr[3:0], g: ~pal_addr[3:0], b: ~pal_addr[3:0]};
            end else begin
                rgb <= '{r: byte0[7:4], g: byte0[3:0], b: pal_q[7:4]};
            end
        end
    end

endmodule

// File: hw/blank_delay.sv
`timescale 1ns/1ps

module blank_delay (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    input  logic                  lhbl,
    input  logic                  lvbl,
    input  colmix_video_pkg::rgb_t rgb_in,
    output logic                  lhbl_dly,
    output logic                  lvbl_dly,
    output colmix_video_pkg::rgb_t rgb_out
);

    // one stage of the line, colour travels with its blanking levels
    typedef struct packed {
        colmix_video_pkg::rgb_t rgb;
        logic                   lhbl;
        logic                   lvbl;
    } dly_t;

    // levels sampled on the same edge as the colour register in the core
    logic lhbl_q;
    logic lvbl_q;

    dly_t line [colmix_video_pkg::PXL_DLY];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lhbl_q <= 1'b0;
            lvbl_q <= 1'b0;
            for (int i = 0; i < colmix_video_pkg::PXL_DLY; i++) begin
                line[i] <= '0;
            end
        end else if (pxl_cen) begin
            lhbl_q <= lhbl;
            lvbl_q <= lvbl;
            // stage 0 takes the word the core captured on the previous pxl_cen
            line[0] <= '{rgb: rgb_in, lhbl: lhbl_q, lvbl: lvbl_q};
            for (int i = 1; i < colmix_video_pkg::PXL_DLY; i++) begin
                line[i] <= line[i-1];
            end
        end
    end

    // last stage drives the video outputs
    assign rgb_out  = line[colmix_video_pkg::PXL_DLY-1].rgb;
    assign lhbl_dly = line[colmix_video_pkg::PXL_DLY-1].lhbl;
    assign lvbl_dly = line[colmix_video_pkg::PXL_DLY-1].lvbl;

endmodule

// File: hw/pal_ram.sv
`timescale 1ns/1ps

module pal_ram (
    input  logic                              clk,
    input  colmix_mem_pkg::pal_wr_t           wr,
    input  logic [colmix_mem_pkg::PAL_AW-1:0] rd_addr,
    output logic [7:0]                        q
);

    // byte wide storage
    // even address holds red and green, odd address holds blue
    logic [7:0] mem [colmix_mem_pkg::PAL_DEPTH];

    // port 0, CPU writes
    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // port 1, mixer reads one clock after the address
    // a write to the same address on this edge is seen one read later
    always_ff @(posedge clk) begin
        q <= mem[rd_addr];
    end

endmodule

// File: hw/prio_prom.sv
`timescale 1ns/1ps

module prio_prom (
    input  logic                               clk,
    input  colmix_mem_pkg::prio_wr_t           wr,
    input  logic [colmix_mem_pkg::PRIO_AW-1:0] addr,
    output colmix_video_pkg::layer_sel_t       prio
);

    // table contents, one layer code for each combination of
    // scroll nibble, transparency and window bits
    logic [1:0] mem [colmix_mem_pkg::PRIO_DEPTH];

    // program port
    // the loader fills the table before video starts and may reload
    // it during vertical blank
    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // lookup has no clock
    // the palette address has to settle within the same pixel phase
    assign prio = mem[addr];

endmodule

// File: hw/colmix_mem_pkg.sv
package colmix_mem_pkg;

    // palette RAM is 512 entries of two bytes
    localparam int PAL_AW = 10;

    // priority PROM address width, 256 entries
    localparam int PRIO_AW = 8;

    // CPU side write into the palette RAM
    // we is a single clock strobe
    typedef struct packed {
        logic              we;
        logic [PAL_AW-1:0] addr;
        logic [7:0]        data;
    } pal_wr_t;

    // loader write into the priority PROM
    typedef struct packed {
        logic               we;
        logic [PRIO_AW-1:0] addr;
        logic [1:0]         data;
    } prio_wr_t;

    // sizes of both stores in entries
    localparam int PAL_DEPTH  = 1 << PAL_AW;
    localparam int PRIO_DEPTH = 1 << PRIO_AW;

endpackage

// File: hw/colmix_video_pkg.sv
package colmix_video_pkg;

    // pixel periods between the colour register and the video outputs
    localparam int PXL_DLY = 8;

    // priority PROM output, one layer per pixel
    typedef logic [1:0] layer_sel_t;

    // codes out of the priority table
    // any code other than these two picks the scroll layer
    localparam layer_sel_t CHAR_SEL = 2'd3;
    localparam layer_sel_t OBJ_SEL  = 2'd2;

    // palette bank of each layer, top two bits of the 9-bit palette address
    localparam logic [1:0] CHAR_PAL = 2'd3;
    localparam logic [1:0] OBJ_PAL  = 2'd2;
    localparam logic [1:0] SCR_PAL  = 2'd1;

    // character layer pixel
    // idx of 2'b11 is the transparent colour
    typedef struct packed {
        logic       win;
        logic [3:0] grp;
        logic [1:0] idx;
    } char_pxl_t;

    // scroll layer pixel, code[3:0] also goes to the priority table
    typedef struct packed {
        logic       win;
        logic [6:0] code;
    } scr_pxl_t;

    // object pixel, col of 4'hf means nothing drawn here
    typedef struct packed {
        logic [2:0] grp;
        logic [3:0] col;
    } obj_pxl_t;

    // 12-bit colour word as sent to the video DAC
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

endpackage
